// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= list.f
TB_TOP    ?= lane_reorder_tb
RTL_TOP   ?= lane_reorder_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Result: PASSED

RTL_SRCS = design/lane_reorder_pkg.sv design/lane_scan_counter.sv \
           design/lane_order_fsm.sv design/lane_swap.sv design/lane_reorder_top.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

$(BUILD_DIR)/V$(TB_TOP): $(RTL_SRCS) verification/lane_reorder_tb.sv \
		verification/lane_reorder_vectors.svh $(FILELIST)
	$(VERILATOR) --binary --timing --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "simulation did not pass"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/lane_order_fsm.sv
module lane_order_fsm
#(
    parameter int N_LANES = 20
)
(
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_enable,
    input  logic                        i_deskew_done,
    input  logic                        i_rf_reset_order,
    input  logic [N_LANES*NB_ID-1:0]    i_logical_rx_id,
    input  logic [NB_ID-1:0]            i_lane_index,
    input  logic                        i_last_lane,
    output logic                        o_scan_clear,
    output logic                        o_scan_step,
    output logic [N_LANES*NB_ID-1:0]    o_selectors,
    output logic                        o_update_selectors,
    output logic                        o_order_done,
    output logic                        o_order_error
);

    localparam int NB_ID = (N_LANES > 1) ? $clog2(N_LANES) : 1;

    logic [lane_reorder_pkg::NB_ORDER_STATE-1:0] state;
    logic [lane_reorder_pkg::NB_ORDER_STATE-1:0] next_state;

    logic                           deskew_prev;
    logic                           start_order;
    logic [N_LANES-1:0][NB_ID-1:0]  rx_ids;
    logic [N_LANES-1:0][NB_ID-1:0]  sel_table;
    logic [N_LANES-1:0]             filled;
    logic                           bad_map;
    logic [NB_ID-1:0]               scan_id;
    logic                           scan_id_out_of_range;
    logic                           scan_id_bad;
    logic                           update_pulse;

    assign rx_ids      = i_logical_rx_id;
    assign start_order = (i_deskew_done & ~deskew_prev) | i_rf_reset_order;

    assign scan_id              = rx_ids[i_lane_index];
    assign scan_id_out_of_range = (int'(scan_id) >= N_LANES);
    assign scan_id_bad          = scan_id_out_of_range ? 1'b1 : filled[scan_id];

    always_comb
    begin
        next_state = state;
        if (start_order)
        begin
            next_state = lane_reorder_pkg::ORDER_SCAN; // restart wins over every state.
        end
        else
        begin
            case (state)
                lane_reorder_pkg::ORDER_SCAN:
                begin
                    if (i_last_lane)
                    begin
                        next_state = lane_reorder_pkg::ORDER_CHECK;
                    end
                end
                lane_reorder_pkg::ORDER_CHECK:
                begin
                    next_state = bad_map ? lane_reorder_pkg::ORDER_ERROR
                                         : lane_reorder_pkg::ORDER_DONE;
                end
                default:
                begin
                    next_state = state; // idle, done and error wait for a start.
                end
            endcase
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            state        <= lane_reorder_pkg::ORDER_IDLE;
            deskew_prev  <= 1'b0;
            sel_table    <= '0;
            filled       <= '0;
            bad_map      <= 1'b0;
            update_pulse <= 1'b0;
        end
        else if (i_enable)
        begin
            state        <= next_state;
            deskew_prev  <= i_deskew_done;
            update_pulse <= (state == lane_reorder_pkg::ORDER_CHECK) && !bad_map && !start_order;
            if (start_order)
            begin
                sel_table <= '0;
                filled    <= '0;
                bad_map   <= 1'b0;
            end
            else if (state == lane_reorder_pkg::ORDER_SCAN)
            begin
                if (scan_id_bad)
                begin
                    bad_map <= 1'b1; // duplicate or out-of-range id.
                end
                else
                begin
                    filled[scan_id]    <= 1'b1;
                    sel_table[scan_id] <= i_lane_index;
                end
            end
        end
    end

    assign o_scan_clear       = start_order;
    assign o_scan_step        = (state == lane_reorder_pkg::ORDER_SCAN);
    assign o_selectors        = sel_table;
    assign o_update_selectors = update_pulse;
    assign o_order_done       = (state == lane_reorder_pkg::ORDER_DONE);
    assign o_order_error      = (state == lane_reorder_pkg::ORDER_ERROR);

endmodule

// File: design/lane_reorder_pkg.sv
package lane_reorder_pkg;

    // one PCS block is the 2-bit sync header plus a 64-bit payload.
    localparam int NB_BLOCK        = 66;

    // tag bit carried on top of each block in the lane FIFO.
    localparam int NB_TAG          = 1;

    localparam int NB_FIFO_WORD    = NB_BLOCK + NB_TAG; // 67 bits per lane word.

    localparam int N_LANES_DEFAULT = 20; // lane count of a 100G PCS.

    localparam int NB_ORDER_STATE  = 3;

    localparam logic [NB_ORDER_STATE-1:0] ORDER_IDLE  = 3'd0;
    localparam logic [NB_ORDER_STATE-1:0] ORDER_SCAN  = 3'd1;
    localparam logic [NB_ORDER_STATE-1:0] ORDER_CHECK = 3'd2;
    localparam logic [NB_ORDER_STATE-1:0] ORDER_DONE  = 3'd3;
    localparam logic [NB_ORDER_STATE-1:0] ORDER_ERROR = 3'd4;

endpackage

// File: design/lane_reorder_top.sv
module lane_reorder_top
#(
    parameter int N_LANES = lane_reorder_pkg::N_LANES_DEFAULT
)
(
    input  logic                                                i_clock,
    input  logic                                                i_reset,
    input  logic                                                i_enable,
    input  logic                                                i_valid,
    input  logic                                                i_deskew_done,
    input  logic                                                i_rf_reset_order,
    input  logic [N_LANES*NB_ID-1:0]                            i_logical_rx_id,
    input  logic [N_LANES*lane_reorder_pkg::NB_FIFO_WORD-1:0]   i_data,
    output logic [N_LANES*lane_reorder_pkg::NB_BLOCK-1:0]       o_data,
    output logic [N_LANES-1:0]                                  o_tag,
    output logic                                                o_valid,
    output logic                                                o_order_done,
    output logic                                                o_order_error
);

    localparam int NB_ID = (N_LANES > 1) ? $clog2(N_LANES) : 1;

    logic                       scan_clear;
    logic                       scan_step;
    logic [NB_ID-1:0]           lane_index;
    logic                       last_lane;
    logic [N_LANES*NB_ID-1:0]   selectors;
    logic                       update_selectors;

    lane_scan_counter #(.N_LANES(N_LANES)) u_scan_counter
    (
        .i_clock            (i_clock),
        .i_reset            (i_reset),
        .i_enable           (i_enable),
        .i_clear            (scan_clear),
        .i_step             (scan_step),
        .o_lane_index       (lane_index),
        .o_last_lane        (last_lane)
    );

    lane_order_fsm #(.N_LANES(N_LANES)) u_order_fsm
    (
        .i_clock            (i_clock),
        .i_reset            (i_reset),
        .i_enable           (i_enable),
        .i_deskew_done      (i_deskew_done),
        .i_rf_reset_order   (i_rf_reset_order),
        .i_logical_rx_id    (i_logical_rx_id),
        .i_lane_index       (lane_index),
        .i_last_lane        (last_lane),
        .o_scan_clear       (scan_clear),
        .o_scan_step        (scan_step),
        .o_selectors        (selectors),
        .o_update_selectors (update_selectors),
        .o_order_done       (o_order_done),
        .o_order_error      (o_order_error)
    );

    lane_swap #(.N_LANES(N_LANES)) u_lane_swap
    (
        .i_clock            (i_clock),
        .i_reset            (i_reset),
        .i_enable           (i_enable),
        .i_valid            (i_valid),
        .i_order_done       (o_order_done),
        .i_update_selectors (update_selectors),
        .i_selectors        (selectors),
        .i_data             (i_data),
        .o_data             (o_data),
        .o_tag              (o_tag),
        .o_valid            (o_valid)
    );

endmodule

// File: design/lane_scan_counter.sv
module lane_scan_counter
#(
    parameter int N_LANES = 20
)
(
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_enable,
    input  logic                i_clear,
    input  logic                i_step,
    output logic [NB_ID-1:0]    o_lane_index,
    output logic                o_last_lane
);

    localparam int NB_ID = (N_LANES > 1) ? $clog2(N_LANES) : 1;

    localparam logic [NB_ID-1:0] LAST_INDEX = NB_ID'(N_LANES - 1);

    logic [NB_ID-1:0] lane_index;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            lane_index <= '0;
        end
        else if (i_enable)
        begin
            if (i_clear)
            begin
                lane_index <= '0;
            end
            else if (i_step)
            begin
                // wraps so the next scan starts from lane zero.
                lane_index <= (lane_index == LAST_INDEX) ? '0 : lane_index + 1'b1;
            end
        end
    end

    assign o_lane_index = lane_index;
    assign o_last_lane  = (lane_index == LAST_INDEX); // tells the FSM the scan ends here.

endmodule

// File: design/lane_swap.sv
module lane_swap
#(
    parameter int N_LANES = 20
)
(
    input  logic                                                i_clock,
    input  logic                                                i_reset,
    input  logic                                                i_enable,
    input  logic                                                i_valid,
    input  logic                                                i_order_done,
    input  logic                                                i_update_selectors,
    input  logic [N_LANES*NB_ID-1:0]                            i_selectors,
    input  logic [N_LANES*lane_reorder_pkg::NB_FIFO_WORD-1:0]   i_data,
    output logic [N_LANES*lane_reorder_pkg::NB_BLOCK-1:0]       o_data,
    output logic [N_LANES-1:0]                                  o_tag,
    output logic                                                o_valid
);

    localparam int NB_ID = (N_LANES > 1) ? $clog2(N_LANES) : 1;

    logic [N_LANES-1:0][lane_reorder_pkg::NB_FIFO_WORD-1:0] capture_q;
    logic [N_LANES-1:0][NB_ID-1:0]                          shadow_sel;
    logic [N_LANES-1:0][lane_reorder_pkg::NB_FIFO_WORD-1:0] swapped;
    logic [N_LANES-1:0][lane_reorder_pkg::NB_BLOCK-1:0]     data_q;
    logic [N_LANES-1:0]                                     tag_q;
    logic                                                   capture_valid;
    logic                                                   out_valid;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            capture_q     <= '0;
            capture_valid <= 1'b0;
        end
        else if (i_enable)
        begin
            capture_valid <= i_valid & i_order_done;
            if (!i_order_done)
            begin
                capture_q <= '0; // no data passes until the lane order is known.
            end
            else if (i_valid)
            begin
                capture_q <= i_data;
            end
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            shadow_sel <= '0;
        end
        else if (i_enable && i_update_selectors)
        begin
            shadow_sel <= i_selectors;
        end
    end

    // logical slot k takes the physical lane named by selector k.
    always_comb
    begin
        for (int k = 0; k < N_LANES; k++)
        begin
            swapped[k] = capture_q[shadow_sel[k]];
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            data_q    <= '0;
            tag_q     <= '0;
            out_valid <= 1'b0;
        end
        else if (i_enable)
        begin
            out_valid <= capture_valid;
            for (int k = 0; k < N_LANES; k++)
            begin
                data_q[k] <= swapped[k][lane_reorder_pkg::NB_BLOCK-1:0];
                tag_q[k]  <= swapped[k][lane_reorder_pkg::NB_FIFO_WORD-1]; // tag is the top bit.
            end
        end
    end

    assign o_data  = data_q;
    assign o_tag   = tag_q;
    assign o_valid = out_valid;

endmodule

// File: list.f
+incdir+verification
design/lane_reorder_pkg.sv
design/lane_scan_counter.sv
design/lane_order_fsm.sv
design/lane_swap.sv
design/lane_reorder_top.sv
verification/lane_reorder_tb.sv

// File: verification/lane_reorder_vectors.svh
`ifndef LANE_REORDER_VECTORS_SVH
`define LANE_REORDER_VECTORS_SVH

// each entry gives a name, the ids {lane3, lane2, lane1, lane0} and whether an error is expected.
// a set bit i of the gap mask drops i_enable on the i-th cycle after the start, repeating.
// the word count sets the data phase, and the last flag starts ordering with i_deskew_done.
localparam int N_TESTS = 6;

string       test_name   [N_TESTS] = '{"identity", "scramble_a", "scramble_b_gaps",
                                       "duplicate_id", "duplicate_gaps", "deskew_restart"};
logic [7:0]  test_ids    [N_TESTS] = '{{2'd3, 2'd2, 2'd1, 2'd0},
                                       {2'd1, 2'd3, 2'd0, 2'd2},
                                       {2'd1, 2'd0, 2'd2, 2'd3},
                                       {2'd0, 2'd2, 2'd2, 2'd1},
                                       {2'd3, 2'd3, 2'd1, 2'd0},
                                       {2'd0, 2'd1, 2'd2, 2'd3}};
logic        test_err    [N_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0};
logic [15:0] test_gap    [N_TESTS] = '{16'h0000, 16'h0000, 16'h0a24,
                                       16'h0000, 16'h0110, 16'h4002};
int          test_words  [N_TESTS] = '{6, 8, 8, 4, 4, 6};
logic        test_deskew [N_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

`endif

// File: verification/lane_reorder_tb.sv
module lane_reorder_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_LANES = 4;
    localparam int NB_ID   = 2;
    localparam int NB_WORD = lane_reorder_pkg::NB_FIFO_WORD;
    localparam int NB_BLK  = lane_reorder_pkg::NB_BLOCK;

    `include "lane_reorder_vectors.svh"

    logic                        i_clock;
    logic                        i_reset;
    logic                        i_enable;
    logic                        i_valid;
    logic                        i_deskew_done;
    logic                        i_rf_reset_order;
    logic [N_LANES*NB_ID-1:0]    i_logical_rx_id;
    logic [N_LANES*NB_WORD-1:0]  i_data;
    logic [N_LANES*NB_BLK-1:0]   o_data;
    logic [N_LANES-1:0]          o_tag;
    logic                        o_valid;
    logic                        o_order_done;
    logic                        o_order_error;

    logic [15:0]                 lfsr_state = 16'd17575;
    logic [N_LANES*NB_WORD-1:0]  drv_data;
    logic [N_LANES*NB_WORD-1:0]  st1_data;
    logic [N_LANES*NB_WORD-1:0]  st2_data;
    logic                        drv_valid;
    logic                        st1_valid;
    logic                        st2_valid;
    logic [N_LANES*NB_BLK-1:0]   hold_data;
    logic [N_LANES-1:0]          hold_tag;
    logic                        hold_valid;
    logic                        cur_en;
    logic                        edge_en;
    logic                        finished;
    string                       cur_name;
    logic [7:0]                  cur_ids;
    logic [15:0]                 cur_gap;
    int                          cur_words;
    int                          cyc;
    int                          sent;
    int                          drain;
    int                          guard;
    int                          latency;
    int                          waited;
    int                          test_errors;
    int                          errors_total;
    int                          tests_failed;
    int                          budget;

    lane_reorder_top #(.N_LANES(N_LANES)) i_dut
    (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_enable         (i_enable),
        .i_valid          (i_valid),
        .i_deskew_done    (i_deskew_done),
        .i_rf_reset_order (i_rf_reset_order),
        .i_logical_rx_id  (i_logical_rx_id),
        .i_data           (i_data),
        .o_data           (o_data),
        .o_tag            (o_tag),
        .o_valid          (o_valid),
        .o_order_done     (o_order_done),
        .o_order_error    (o_order_error)
    );

    initial
    begin
        i_clock = 1'b0;
        forever #20 i_clock = ~i_clock;
    end

    // 16-bit Fibonacci LFSR with taps at bits 16, 14, 13 and 11.
    function automatic logic next_random_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    task automatic drive_random_word();
        for (int i = 0; i < N_LANES*NB_WORD; i++)
        begin
            drv_data[i] = next_random_bit();
        end
        drv_valid = next_random_bit();
        i_data  <= drv_data;
        i_valid <= drv_valid;
    endtask

    task automatic check_value(input string what, input logic [66:0] expv,
                               input logic [66:0] actv);
        if (expv !== actv)
        begin
            $display("ERROR %s %s: expected %h, actual %h", cur_name, what, expv, actv);
            test_errors++;
        end
    endtask

    // the model inverts the id map so slot k holds the lane whose id is k.
    task automatic compare_output();
        int src;
        check_value("o_valid", 67'(st2_valid), 67'(o_valid));
        if (st2_valid)
        begin
            for (int k = 0; k < N_LANES; k++)
            begin
                src = 0;
                for (int p = 0; p < N_LANES; p++)
                begin
                    if (cur_ids[NB_ID*p +: NB_ID] == k)
                    begin
                        src = p;
                    end
                end
                check_value($sformatf("o_data[%0d]", k), 67'(st2_data[NB_WORD*src +: NB_BLK]),
                            67'(o_data[NB_BLK*k +: NB_BLK]));
                check_value($sformatf("o_tag[%0d]", k), 67'(st2_data[NB_WORD*src + NB_BLK]),
                            67'(o_tag[k]));
            end
        end
    endtask

    task automatic next_enable();
        cur_en = !cur_gap[cyc % 16];
        cyc++;
        i_enable <= cur_en;
    endtask

    task automatic start_and_wait(input logic by_deskew);
        @(posedge i_clock);
        i_enable <= 1'b1;
        i_deskew_done <= 1'b0;
        @(posedge i_clock);
        i_logical_rx_id <= cur_ids;
        if (by_deskew)
        begin
            i_deskew_done <= 1'b1;
        end
        else
        begin
            i_rf_reset_order <= 1'b1;
        end
        @(posedge i_clock); // the start event is sampled here.
        i_rf_reset_order <= 1'b0;
        cyc = 0;
        latency = 0;
        waited = 0;
        finished = 1'b0;
        next_enable();
        while (!finished && waited < N_LANES + 1 + 16)
        begin
            @(posedge i_clock);
            if (cur_en)
            begin
                latency++;
            end
            next_enable();
            @(negedge i_clock);
            finished = o_order_done | o_order_error;
            waited++;
        end
        if (!finished)
        begin
            $display("test %s: neither done nor error was raised in time", cur_name);
            test_errors++;
        end
        else
        begin
            check_value("done latency", 67'(N_LANES + 1), 67'(latency));
        end
    endtask

    task automatic run_data_phase(input logic exp_err);
        st1_valid = 1'b0;
        st2_valid = 1'b0;
        drv_valid = 1'b0;
        sent = 0;
        drain = 0;
        guard = 0;
        hold_data = o_data;
        hold_tag = o_tag;
        hold_valid = o_valid;
        while ((sent < cur_words || drain < 3) && guard < 200)
        begin
            @(posedge i_clock);
            edge_en = cur_en;
            if (cur_en)
            begin
                st2_valid = st1_valid;
                st2_data = st1_data;
                st1_valid = drv_valid & !exp_err;
                st1_data = drv_data;
                if (sent == cur_words)
                begin
                    drain++;
                end
            end
            next_enable();
            if (cur_en && sent < cur_words)
            begin
                drive_random_word();
                sent++;
            end
            else
            begin
                drv_valid = 1'b0;
                i_valid <= 1'b0;
            end
            @(negedge i_clock);
            if (edge_en)
            begin
                compare_output();
            end
            else
            begin
                check_value("held o_valid", 67'(hold_valid), 67'(o_valid));
                if (hold_data !== o_data || hold_tag !== o_tag)
                begin
                    $display("test %s: outputs changed while i_enable was low", cur_name);
                    test_errors++;
                end
            end
            check_value("o_order_done", 67'(!exp_err), 67'(o_order_done));
            check_value("o_order_error", 67'(exp_err), 67'(o_order_error));
            hold_data = o_data;
            hold_tag = o_tag;
            hold_valid = o_valid;
            guard++;
        end
        if (guard >= 200)
        begin
            $display("test %s: the data phase did not finish", cur_name);
            test_errors++;
        end
    endtask

    task automatic report_test();
        if (test_errors == 0)
        begin
            $display("test %s: ok", cur_name);
        end
        else
        begin
            $display("test %s: %0d errors", cur_name, test_errors);
            tests_failed++;
        end
        errors_total += test_errors;
    endtask

    initial
    begin
        budget = 60;
        for (int t = 0; t < N_TESTS; t++)
        begin
            budget += N_LANES + 4 + test_words[t] + 16;
        end
        #(budget * 2 * 40);
        $display("watchdog: the run took longer than %0d cycles and was stopped", budget * 2);
        $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        i_reset = 1'b1;
        i_enable = 1'b0;
        i_valid = 1'b0;
        i_deskew_done = 1'b0;
        i_rf_reset_order = 1'b0;
        i_logical_rx_id = '0;
        i_data = '0;
        errors_total = 0;
        tests_failed = 0;
        repeat (4) @(posedge i_clock);
        i_reset <= 1'b0;
        i_enable <= 1'b1;
        cur_name = "reset_idle";
        test_errors = 0;
        for (int c = 0; c < 8; c++)
        begin
            @(posedge i_clock);
            drive_random_word();
            @(negedge i_clock);
            if (o_valid || o_order_done || o_order_error || o_data !== '0 || o_tag !== '0)
            begin
                $display("test %s: outputs were active before any ordering", cur_name);
                test_errors++;
            end
        end
        report_test();
        @(posedge i_clock);
        i_valid <= 1'b0;
        for (int t = 0; t < N_TESTS; t++)
        begin
            cur_name = test_name[t];
            cur_ids = test_ids[t];
            cur_gap = test_gap[t];
            cur_words = test_words[t];
            test_errors = 0;
            start_and_wait(test_deskew[t]);
            if (finished)
            begin
                check_value("error outcome", 67'(test_err[t]), 67'(o_order_error));
                run_data_phase(test_err[t]);
            end
            report_test();
        end
        $display("tests run %0d, failed %0d, errors %0d", N_TESTS + 1, tests_failed,
                 errors_total);
        if (errors_total == 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
